// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exec_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
src/exec_pkg.sv
src/uop_issue.sv
src/alu32.sv
src/shifter32.sv
src/execute.sv
src/wb_latch.sv
src/gpr_file.sv
src/exec_core.sv
test/tb_clock.sv
test/tb_exec_core.sv

// ==== src/alu32.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu32 import exec_pkg::*; (
  input  alu_op_e           op,
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  output logic [data_w-1:0] result,
  output logic [data_w-1:0] flags
);

  logic              is_sub;
  logic              is_arith;
  logic [data_w-1:0] b_eff;
  logic [data_w:0]   sum;
  logic              cf;
  logic              of;

  // one adder, sub is a plus inverted b plus one
  assign is_sub   = (op == op_sub);
  assign is_arith = is_sub || (op == op_add);
  assign b_eff    = is_sub ? ~b : b;
  assign sum      = {1'b0, a} + {1'b0, b_eff} + {{data_w{1'b0}}, is_sub};

  always_comb begin
    case (op)
      op_and:  result = a & b;
      op_or:   result = a | b;
      op_xor:  result = a ^ b;
      default: result = sum[data_w-1:0];
    endcase
  end

  // x86 borrow is the inverted carry out on sub
  assign cf = is_arith & (sum[data_w] ^ is_sub);

  // operand signs agree but the result sign flips
  assign of = is_arith & (a[data_w-1] == b_eff[data_w-1])
            & (result[data_w-1] != a[data_w-1]);

  always_comb begin
    flags          = '0;
    flags[flag_cf] = cf;
    flags[flag_zf] = (result == '0);
    flags[flag_sf] = result[data_w-1];
    flags[flag_of] = of;
  end

endmodule

`default_nettype wire

// ==== src/exec_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_core import exec_pkg::*; (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 issue,
  input  logic                 stall,
  input  alu_op_e              op,
  input  logic [data_w-1:0]    a,
  input  logic [data_w-1:0]    b,
  input  logic [data_w-1:0]    c,
  input  logic [reg_sel_w-1:0] dr1,
  input  logic [reg_sel_w-1:0] dr2,
  input  logic [reg_sel_w-1:0] rd_sel,
  output logic [data_w-1:0]    rd_data,
  output logic [data_w-1:0]    flags,
  output logic                 dep_v_ld_gpr1,
  output logic                 dep_v_ld_gpr2,
  output logic                 dep_v_ld_flags
);

  // EX latches
  logic                 ex_v;
  alu_op_e              ex_op;
  logic [data_w-1:0]    ex_a;
  logic [data_w-1:0]    ex_b;
  logic [data_w-1:0]    ex_c;
  logic [reg_sel_w-1:0] ex_dr1;
  logic [reg_sel_w-1:0] ex_dr2;

  // WB next values
  logic                 wb_v_next;
  logic [data_w-1:0]    wb_result_a_next;
  logic [data_w-1:0]    wb_result_b_next;
  logic [data_w-1:0]    wb_flags_next;
  logic                 wb_ld_gpr1_next;
  logic                 wb_ld_gpr2_next;
  logic                 wb_ld_flags_next;
  logic [reg_sel_w-1:0] wb_dr1_next;
  logic [reg_sel_w-1:0] wb_dr2_next;

  // WB latches
  logic                 wb_v;
  logic                 wb_ld_gpr1;
  logic                 wb_ld_gpr2;
  logic                 wb_ld_flags;
  logic [reg_sel_w-1:0] wb_dr1;
  logic [reg_sel_w-1:0] wb_dr2;
  logic [data_w-1:0]    wb_result_a;
  logic [data_w-1:0]    wb_result_b;
  logic [data_w-1:0]    wb_flags;

  logic                 ld_latches;

  // the whole pipe freezes together under stall
  assign ld_latches = ~stall;

  uop_issue u_uop_issue (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .issue  (issue),
    .stall  (stall),
    .op     (op),
    .a      (a),
    .b      (b),
    .c      (c),
    .dr1    (dr1),
    .dr2    (dr2),
    .ex_v   (ex_v),
    .ex_op  (ex_op),
    .ex_a   (ex_a),
    .ex_b   (ex_b),
    .ex_c   (ex_c),
    .ex_dr1 (ex_dr1),
    .ex_dr2 (ex_dr2)
  );

  execute u_execute (
    .ex_v             (ex_v),
    .ex_op            (ex_op),
    .ex_a             (ex_a),
    .ex_b             (ex_b),
    .ex_c             (ex_c),
    .ex_dr1           (ex_dr1),
    .ex_dr2           (ex_dr2),
    .wb_v_next        (wb_v_next),
    .wb_result_a_next (wb_result_a_next),
    .wb_result_b_next (wb_result_b_next),
    .wb_flags_next    (wb_flags_next),
    .wb_ld_gpr1_next  (wb_ld_gpr1_next),
    .wb_ld_gpr2_next  (wb_ld_gpr2_next),
    .wb_ld_flags_next (wb_ld_flags_next),
    .wb_dr1_next      (wb_dr1_next),
    .wb_dr2_next      (wb_dr2_next),
    .dep_v_ld_gpr1    (dep_v_ld_gpr1),
    .dep_v_ld_gpr2    (dep_v_ld_gpr2),
    .dep_v_ld_flags   (dep_v_ld_flags)
  );

  wb_latch u_wb_latch (
    .CLK              (CLK),
    .rst_n            (rst_n),
    .ld_latches       (ld_latches),
    .wb_v_next        (wb_v_next),
    .wb_result_a_next (wb_result_a_next),
    .wb_result_b_next (wb_result_b_next),
    .wb_flags_next    (wb_flags_next),
    .wb_ld_gpr1_next  (wb_ld_gpr1_next),
    .wb_ld_gpr2_next  (wb_ld_gpr2_next),
    .wb_ld_flags_next (wb_ld_flags_next),
    .wb_dr1_next      (wb_dr1_next),
    .wb_dr2_next      (wb_dr2_next),
    .wb_v             (wb_v),
    .wb_ld_gpr1       (wb_ld_gpr1),
    .wb_ld_gpr2       (wb_ld_gpr2),
    .wb_ld_flags      (wb_ld_flags),
    .wb_dr1           (wb_dr1),
    .wb_dr2           (wb_dr2),
    .wb_result_a      (wb_result_a),
    .wb_result_b      (wb_result_b),
    .wb_flags         (wb_flags)
  );

  gpr_file u_gpr_file (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .stall       (stall),
    .wb_v        (wb_v),
    .wb_ld_gpr1  (wb_ld_gpr1),
    .wb_ld_gpr2  (wb_ld_gpr2),
    .wb_ld_flags (wb_ld_flags),
    .wb_dr1      (wb_dr1),
    .wb_dr2      (wb_dr2),
    .wb_result_a (wb_result_a),
    .wb_result_b (wb_result_b),
    .wb_flags    (wb_flags),
    .rd_sel      (rd_sel),
    .rd_data     (rd_data),
    .flags       (flags)
  );

endmodule

`default_nettype wire

// ==== src/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  // datapath and register file sizing
  localparam int data_w    = 32;
  localparam int reg_sel_w = 3;
  localparam int num_gprs  = 8;

  // shift count taken from the low bits of b
  localparam int shamt_w = 5;

  // bit positions in the 32-bit flags word
  localparam int flag_cf = 0;
  localparam int flag_zf = 6;
  localparam int flag_sf = 7;
  localparam int flag_of = 11;

  // micro-op opcodes seen by the EX stage
  typedef enum logic [3:0] {
    op_add     = 4'd0,
    op_sub     = 4'd1,
    op_and     = 4'd2,
    op_or      = 4'd3,
    op_xor     = 4'd4,
    // sub that only writes flags
    op_cmp     = 4'd5,
    op_shl     = 4'd6,
    op_shr     = 4'd7,
    // passes b to dr1
    op_mov     = 4'd8,
    // compare c with a, write b or swap a into the accumulator
    op_cmpxchg = 4'd9
  } alu_op_e;

endpackage

`default_nettype wire

// ==== src/execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute import exec_pkg::*; (
  input  logic                 ex_v,
  input  alu_op_e              ex_op,
  input  logic [data_w-1:0]    ex_a,
  input  logic [data_w-1:0]    ex_b,
  input  logic [data_w-1:0]    ex_c,
  input  logic [reg_sel_w-1:0] ex_dr1,
  input  logic [reg_sel_w-1:0] ex_dr2,
  output logic                 wb_v_next,
  output logic [data_w-1:0]    wb_result_a_next,
  output logic [data_w-1:0]    wb_result_b_next,
  output logic [data_w-1:0]    wb_flags_next,
  output logic                 wb_ld_gpr1_next,
  output logic                 wb_ld_gpr2_next,
  output logic                 wb_ld_flags_next,
  output logic [reg_sel_w-1:0] wb_dr1_next,
  output logic [reg_sel_w-1:0] wb_dr2_next,
  output logic                 dep_v_ld_gpr1,
  output logic                 dep_v_ld_gpr2,
  output logic                 dep_v_ld_flags
);

  alu_op_e           alu_op;
  logic [data_w-1:0] alu_a;
  logic [data_w-1:0] alu_b;
  logic [data_w-1:0] alu_result;
  logic [data_w-1:0] alu_flags;
  logic [data_w-1:0] shift_result;
  logic [data_w-1:0] shift_flags;
  logic              is_shift;
  logic              is_xchg;
  logic              zf;

  // compares run as sub, cmpxchg tests c minus a
  assign is_xchg = (ex_op == op_cmpxchg);
  assign alu_op  = (ex_op == op_cmp || is_xchg) ? op_sub : ex_op;
  assign alu_a   = is_xchg ? ex_c : ex_a;
  assign alu_b   = is_xchg ? ex_a : ex_b;

  alu32 u_alu32 (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .flags  (alu_flags)
  );

  shifter32 u_shifter32 (
    .dir_left (ex_op == op_shl),
    .a        (ex_a),
    .count    (ex_b[shamt_w-1:0]),
    .result   (shift_result),
    .flags    (shift_flags)
  );

  assign is_shift = (ex_op == op_shl) || (ex_op == op_shr);
  assign zf       = alu_flags[flag_zf];

  // mov and cmpxchg both hand b to dr1, the accumulator gets a
  assign wb_result_a_next = is_shift ? shift_result :
                            (ex_op == op_mov || is_xchg) ? ex_b : alu_result;
  assign wb_result_b_next = ex_a;
  assign wb_flags_next    = is_shift ? shift_flags : alu_flags;

  // load intents, cmpxchg picks its target by zf
  assign dep_v_ld_gpr1  = ex_v & (is_xchg ? zf : (ex_op != op_cmp));
  assign dep_v_ld_gpr2  = ex_v & is_xchg & ~zf;
  assign dep_v_ld_flags = ex_v & (ex_op != op_mov);

  assign wb_v_next        = ex_v;
  assign wb_ld_gpr1_next  = dep_v_ld_gpr1;
  assign wb_ld_gpr2_next  = dep_v_ld_gpr2;
  assign wb_ld_flags_next = dep_v_ld_flags;
  assign wb_dr1_next      = ex_dr1;
  assign wb_dr2_next      = ex_dr2;

endmodule

`default_nettype wire

// ==== src/gpr_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module gpr_file import exec_pkg::*; (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 stall,
  input  logic                 wb_v,
  input  logic                 wb_ld_gpr1,
  input  logic                 wb_ld_gpr2,
  input  logic                 wb_ld_flags,
  input  logic [reg_sel_w-1:0] wb_dr1,
  input  logic [reg_sel_w-1:0] wb_dr2,
  input  logic [data_w-1:0]    wb_result_a,
  input  logic [data_w-1:0]    wb_result_b,
  input  logic [data_w-1:0]    wb_flags,
  input  logic [reg_sel_w-1:0] rd_sel,
  output logic [data_w-1:0]    rd_data,
  output logic [data_w-1:0]    flags
);

  logic [data_w-1:0] regs [num_gprs];
  logic              retire;

  assign retire = wb_v & ~stall;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_gprs; i++) begin
        regs[i] <= '0;
      end
      flags <= '0;
    end else if (retire) begin
      if (wb_ld_gpr1) begin
        regs[wb_dr1] <= wb_result_a;
      end
      // second port written last so dr2 wins on a clash
      if (wb_ld_gpr2) begin
        regs[wb_dr2] <= wb_result_b;
      end
      if (wb_ld_flags) begin
        flags <= wb_flags;
      end
    end
  end

  assign rd_data = regs[rd_sel];

endmodule

`default_nettype wire

// ==== src/shifter32.sv ====
`timescale 1ns/100ps
`default_nettype none

module shifter32 import exec_pkg::*; (
  input  logic               dir_left,
  input  logic [data_w-1:0]  a,
  input  logic [shamt_w-1:0] count,
  output logic [data_w-1:0]  result,
  output logic [data_w-1:0]  flags
);

  // one spare bit on each side catches the last bit out
  logic [data_w:0] left_ext;
  logic [data_w:0] right_ext;
  logic            cf;

  assign left_ext  = {1'b0, a} << count;
  assign right_ext = {a, 1'b0} >> count;

  assign result = dir_left ? left_ext[data_w-1:0] : right_ext[data_w:1];

  // spare bit stays zero for a count of zero
  assign cf = dir_left ? left_ext[data_w] : right_ext[0];

  always_comb begin
    flags          = '0;
    flags[flag_cf] = cf;
    flags[flag_zf] = (result == '0);
    flags[flag_sf] = result[data_w-1];
  end

endmodule

`default_nettype wire

// ==== src/uop_issue.sv ====
`timescale 1ns/100ps
`default_nettype none

module uop_issue import exec_pkg::*; (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 issue,
  input  logic                 stall,
  input  alu_op_e              op,
  input  logic [data_w-1:0]    a,
  input  logic [data_w-1:0]    b,
  input  logic [data_w-1:0]    c,
  input  logic [reg_sel_w-1:0] dr1,
  input  logic [reg_sel_w-1:0] dr2,
  output logic                 ex_v,
  output alu_op_e              ex_op,
  output logic [data_w-1:0]    ex_a,
  output logic [data_w-1:0]    ex_b,
  output logic [data_w-1:0]    ex_c,
  output logic [reg_sel_w-1:0] ex_dr1,
  output logic [reg_sel_w-1:0] ex_dr2
);

  // valid bit, a bubble on every free edge without a strobe
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      ex_v <= 1'b0;
    end else if (!stall) begin
      ex_v <= issue;
    end
  end

  // operand latches only move on an accepted strobe
  always_ff @(posedge CLK) begin
    if (issue && !stall) begin
      ex_op  <= op;
      ex_a   <= a;
      ex_b   <= b;
      ex_c   <= c;
      ex_dr1 <= dr1;
      ex_dr2 <= dr2;
    end
  end

endmodule

`default_nettype wire

// ==== src/wb_latch.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_latch import exec_pkg::*; (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 ld_latches,
  input  logic                 wb_v_next,
  input  logic [data_w-1:0]    wb_result_a_next,
  input  logic [data_w-1:0]    wb_result_b_next,
  input  logic [data_w-1:0]    wb_flags_next,
  input  logic                 wb_ld_gpr1_next,
  input  logic                 wb_ld_gpr2_next,
  input  logic                 wb_ld_flags_next,
  input  logic [reg_sel_w-1:0] wb_dr1_next,
  input  logic [reg_sel_w-1:0] wb_dr2_next,
  output logic                 wb_v,
  output logic                 wb_ld_gpr1,
  output logic                 wb_ld_gpr2,
  output logic                 wb_ld_flags,
  output logic [reg_sel_w-1:0] wb_dr1,
  output logic [reg_sel_w-1:0] wb_dr2,
  output logic [data_w-1:0]    wb_result_a,
  output logic [data_w-1:0]    wb_result_b,
  output logic [data_w-1:0]    wb_flags
);

  // valid and write enables
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wb_v        <= 1'b0;
      wb_ld_gpr1  <= 1'b0;
      wb_ld_gpr2  <= 1'b0;
      wb_ld_flags <= 1'b0;
    end else if (ld_latches) begin
      wb_v        <= wb_v_next;
      wb_ld_gpr1  <= wb_ld_gpr1_next;
      wb_ld_gpr2  <= wb_ld_gpr2_next;
      wb_ld_flags <= wb_ld_flags_next;
    end
  end

  // selectors and data
  always_ff @(posedge CLK) begin
    if (ld_latches) begin
      wb_dr1      <= wb_dr1_next;
      wb_dr2      <= wb_dr2_next;
      wb_result_a <= wb_result_a_next;
      wb_result_b <= wb_result_b_next;
      wb_flags    <= wb_flags_next;
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // 40 ns period
  localparam int half_period = 20;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== test/tb_exec_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_exec_core import exec_pkg::*; ();

  localparam int reset_cycles = 5;
  localparam int watchdog_ns  = 200000;

  logic                 clk;
  logic                 rst_n;
  logic                 issue;
  logic                 stall;
  alu_op_e              op;
  logic [data_w-1:0]    a;
  logic [data_w-1:0]    b;
  logic [data_w-1:0]    c;
  logic [reg_sel_w-1:0] dr1;
  logic [reg_sel_w-1:0] dr2;
  logic [reg_sel_w-1:0] rd_sel;
  logic [data_w-1:0]    rd_data;
  logic [data_w-1:0]    flags;
  logic                 dep_v_ld_gpr1;
  logic                 dep_v_ld_gpr2;
  logic                 dep_v_ld_flags;

  // reference register file and flags
  logic [data_w-1:0] model_regs [num_gprs];
  logic [data_w-1:0] model_flags;

  int check_count;
  int error_count;
  int test_count;
  int test_errors_start;

  tb_clock clk_gen (
    .clk (clk)
  );

  exec_core exec_core_inst (
    .CLK            (clk),
    .rst_n          (rst_n),
    .issue          (issue),
    .stall          (stall),
    .op             (op),
    .a              (a),
    .b              (b),
    .c              (c),
    .dr1            (dr1),
    .dr2            (dr2),
    .rd_sel         (rd_sel),
    .rd_data        (rd_data),
    .flags          (flags),
    .dep_v_ld_gpr1  (dep_v_ld_gpr1),
    .dep_v_ld_gpr2  (dep_v_ld_gpr2),
    .dep_v_ld_flags (dep_v_ld_flags)
  );

  task automatic check(input string name, input logic [data_w-1:0] actual,
                       input logic [data_w-1:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("mismatch %s: got 0x%08h expected 0x%08h", name, actual, expected);
    end
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("test %0d %s: %0d errors", test_count, name, error_count - test_errors_start);
    test_errors_start = error_count;
  endtask

  function automatic logic [data_w-1:0] make_flags(input logic cf, input logic [data_w-1:0] r,
                                                   input logic of);
    logic [data_w-1:0] f;
    f          = '0;
    f[flag_cf] = cf;
    f[flag_zf] = (r == '0);
    f[flag_sf] = r[data_w-1];
    f[flag_of] = of;
    return f;
  endfunction

  // expected load intents, values and flags of one micro-op
  task automatic predict(
    input  alu_op_e           uop,
    input  logic [data_w-1:0] opa,
    input  logic [data_w-1:0] opb,
    input  logic [data_w-1:0] opc,
    output logic              ld1,
    output logic              ld2,
    output logic              ldf,
    output logic [data_w-1:0] v1,
    output logic [data_w-1:0] v2,
    output logic [data_w-1:0] fl
  );
    logic [data_w:0]    wide;
    logic [data_w-1:0]  r;
    logic [data_w-1:0]  t;
    logic [shamt_w-1:0] cnt;
    logic               cf;
    logic               of;
    r   = '0;
    cf  = 1'b0;
    of  = 1'b0;
    cnt = opb[shamt_w-1:0];
    case (uop)
      op_add: begin
        wide = {1'b0, opa} + {1'b0, opb};
        r    = wide[data_w-1:0];
        cf   = wide[data_w];
        of   = (opa[data_w-1] == opb[data_w-1]) && (r[data_w-1] != opa[data_w-1]);
      end
      op_sub, op_cmp: begin
        r  = opa - opb;
        cf = (opa < opb);
        of = (opa[data_w-1] != opb[data_w-1]) && (r[data_w-1] != opa[data_w-1]);
      end
      op_and: r = opa & opb;
      op_or:  r = opa | opb;
      op_xor: r = opa ^ opb;
      op_shl: begin
        r = opa << cnt;
        // last bit out sits at the top after one shift less
        if (cnt != '0) begin
          t  = opa << (cnt - 5'd1);
          cf = t[data_w-1];
        end
      end
      op_shr: begin
        r = opa >> cnt;
        if (cnt != '0) begin
          t  = opa >> (cnt - 5'd1);
          cf = t[0];
        end
      end
      op_mov: r = opb;
      op_cmpxchg: begin
        r  = opc - opa;
        cf = (opc < opa);
        of = (opc[data_w-1] != opa[data_w-1]) && (r[data_w-1] != opc[data_w-1]);
      end
      default: r = '0;
    endcase
    fl  = make_flags(cf, r, of);
    ldf = (uop != op_mov);
    ld1 = (uop != op_cmp);
    ld2 = 1'b0;
    v1  = r;
    v2  = opa;
    if (uop == op_cmpxchg) begin
      ld1 = (opa == opc);
      ld2 = !ld1;
      v1  = opb;
    end
  endtask

  task automatic retire_model(input logic [reg_sel_w-1:0] sel1, input logic [reg_sel_w-1:0] sel2,
                              input logic ld1, input logic ld2, input logic ldf,
                              input logic [data_w-1:0] v1, input logic [data_w-1:0] v2,
                              input logic [data_w-1:0] fl);
    if (ld1) begin
      model_regs[sel1] = v1;
    end
    // dr2 goes second so it wins a clash
    if (ld2) begin
      model_regs[sel2] = v2;
    end
    if (ldf) begin
      model_flags = fl;
    end
  endtask

  // each read samples the selector set one falling edge earlier
  task automatic compare_state();
    rd_sel = '0;
    for (int i = 0; i < num_gprs; i++) begin
      @(negedge clk);
      check($sformatf("gpr%0d", i), rd_data, model_regs[i]);
      rd_sel = reg_sel_w'(i + 1);
    end
    check("flags", flags, model_flags);
  endtask

  task automatic check_deps(input logic e1, input logic e2, input logic ef);
    check("dep_v_ld_gpr1", {31'd0, dep_v_ld_gpr1}, {31'd0, e1});
    check("dep_v_ld_gpr2", {31'd0, dep_v_ld_gpr2}, {31'd0, e2});
    check("dep_v_ld_flags", {31'd0, dep_v_ld_flags}, {31'd0, ef});
  endtask

  task automatic step(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
    end
  endtask

  function automatic alu_op_e pick_op(input bit with_compares);
    logic [31:0] r;
    if (with_compares) begin
      r = $urandom % 10;
      return alu_op_e'(r[3:0]);
    end
    r = $urandom % 8;
    case (r)
      32'd5:   return op_shl;
      32'd6:   return op_shr;
      32'd7:   return op_mov;
      default: return alu_op_e'(r[3:0]);
    endcase
  endfunction

  task automatic random_uop(input bit with_compares, output alu_op_e uop,
                            output logic [data_w-1:0] opa, output logic [data_w-1:0] opb,
                            output logic [data_w-1:0] opc,
                            output logic [reg_sel_w-1:0] sel1,
                            output logic [reg_sel_w-1:0] sel2);
    logic [31:0] coin;
    coin = $urandom;
    uop  = pick_op(with_compares);
    opa  = $urandom;
    opb  = $urandom;
    opc  = $urandom;
    // equal operands now and then so zero results show up
    if (coin[2:0] == 3'd0) begin
      opb = opa;
    end
    if (coin[3]) begin
      opc = opa;
    end
    sel1 = coin[10:8];
    sel2 = coin[13:11];
  endtask

  task automatic drive_uop(input alu_op_e uop, input logic [data_w-1:0] opa,
                           input logic [data_w-1:0] opb, input logic [data_w-1:0] opc,
                           input logic [reg_sel_w-1:0] sel1, input logic [reg_sel_w-1:0] sel2);
    issue = 1'b1;
    op    = uop;
    a     = opa;
    b     = opb;
    c     = opc;
    dr1   = sel1;
    dr2   = sel2;
  endtask

  // one micro-op through EX and WB with the pipe otherwise empty
  // starts and ends on a falling edge, three cycles apart
  task automatic run_op(input alu_op_e uop, input logic [data_w-1:0] opa,
                        input logic [data_w-1:0] opb, input logic [data_w-1:0] opc,
                        input logic [reg_sel_w-1:0] sel1, input logic [reg_sel_w-1:0] sel2,
                        input bit watch_deps);
    logic                 ld1;
    logic                 ld2;
    logic                 ldf;
    logic [data_w-1:0]    v1;
    logic [data_w-1:0]    v2;
    logic [data_w-1:0]    fl;
    logic [reg_sel_w-1:0] target;
    predict(uop, opa, opb, opc, ld1, ld2, ldf, v1, v2, fl);
    target = ld2 ? sel2 : sel1;
    drive_uop(uop, opa, opb, opc, sel1, sel2);
    @(negedge clk);
    issue = 1'b0;
    if (watch_deps) begin
      check_deps(ld1, ld2, ldf);
    end
    @(negedge clk);
    // bubble now in EX
    if (watch_deps) begin
      check_deps(1'b0, 1'b0, 1'b0);
    end
    rd_sel = target;
    @(negedge clk);
    retire_model(sel1, sel2, ld1, ld2, ldf, v1, v2, fl);
    check($sformatf("gpr%0d", target), rd_data, model_regs[target]);
    check("flags", flags, model_flags);
  endtask

  task automatic back_to_back(input int n_ops);
    alu_op_e              uop;
    logic [data_w-1:0]    opa;
    logic [data_w-1:0]    opb;
    logic [data_w-1:0]    opc;
    logic [data_w-1:0]    v1;
    logic [data_w-1:0]    v2;
    logic [data_w-1:0]    fl;
    logic [31:0]          r;
    logic [reg_sel_w-1:0] sel1;
    logic [reg_sel_w-1:0] sel2;
    logic                 ld1;
    logic                 ld2;
    logic                 ldf;
    int                   issued;
    int                   cycles;
    issued = 0;
    cycles = 0;
    while (issued < n_ops && cycles < n_ops * 8) begin
      @(negedge clk);
      cycles++;
      r     = $urandom;
      stall = (r[1:0] == 2'd0);
      issue = 1'b0;
      if (!stall) begin
        random_uop(1'b1, uop, opa, opb, opc, sel1, sel2);
        predict(uop, opa, opb, opc, ld1, ld2, ldf, v1, v2, fl);
        retire_model(sel1, sel2, ld1, ld2, ldf, v1, v2, fl);
        drive_uop(uop, opa, opb, opc, sel1, sel2);
        issued++;
      end
    end
    @(negedge clk);
    issue = 1'b0;
    stall = 1'b0;
    // drain EX and WB
    step(3);
    if (issued < n_ops) begin
      error_count++;
      $display("timeout: only %0d of %0d micro-ops were issued", issued, n_ops);
    end
    compare_state();
  endtask

  initial begin : watchdog
    #watchdog_ns;
    $display("timeout: simulation ran past the watchdog limit");
    $display("sim failed");
    $finish;
  end

  initial begin : main
    alu_op_e              uop;
    logic [data_w-1:0]    opa;
    logic [data_w-1:0]    opb;
    logic [data_w-1:0]    opc;
    logic [reg_sel_w-1:0] sel1;
    logic [reg_sel_w-1:0] sel2;
    rst_n             = 1'b0;
    issue             = 1'b0;
    stall             = 1'b0;
    op                = op_add;
    a                 = '0;
    b                 = '0;
    c                 = '0;
    dr1               = '0;
    dr2               = '0;
    rd_sel            = '0;
    check_count       = 0;
    error_count       = 0;
    test_count        = 0;
    test_errors_start = 0;
    model_flags       = '0;
    for (int i = 0; i < num_gprs; i++) begin
      model_regs[i] = '0;
    end
    void'($urandom(75));
    step(reset_cycles);
    rst_n = 1'b1;

    @(negedge clk);
    check_deps(1'b0, 1'b0, 1'b0);
    compare_state();
    finish_test("reset state");

    for (int n = 0; n < 200; n++) begin
      random_uop(1'b0, uop, opa, opb, opc, sel1, sel2);
      run_op(uop, opa, opb, opc, sel1, sel2, 1'b0);
    end
    compare_state();
    finish_test("random alu and shift ops");

    for (int n = 0; n < 40; n++) begin
      random_uop(1'b0, uop, opa, opb, opc, sel1, sel2);
      run_op(op_cmpxchg, opa, opb, opc, sel1, sel2, 1'b1);
      // rd_sel still points at the written register
      if (opa == opc) begin
        check("gpr dr1", rd_data, opb);
        check("flags zf", {31'd0, flags[flag_zf]}, 32'd1);
      end else begin
        check("gpr dr2", rd_data, opa);
        check("flags zf", {31'd0, flags[flag_zf]}, 32'd0);
      end
    end
    // cmp only touches flags
    for (int n = 0; n < 10; n++) begin
      random_uop(1'b0, uop, opa, opb, opc, sel1, sel2);
      run_op(op_cmp, opa, opb, opc, sel1, sel2, 1'b1);
    end
    compare_state();
    finish_test("compare and exchange");

    back_to_back(80);
    finish_test("back-to-back issue with stall");

    for (int n = 0; n < 60; n++) begin
      random_uop(1'b1, uop, opa, opb, opc, sel1, sel2);
      run_op(uop, opa, opb, opc, sel1, sel2, 1'b1);
    end
    compare_state();
    finish_test("dependency strobes");

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
